// File: common/mst_fifo_settings.svh
/*
  Build-time settings for the FIFO bus master
  Included by the packages and by modules that size storage or timers
*/
`ifndef MST_FIFO_SETTINGS_SVH
`define MST_FIFO_SETTINGS_SVH

// Bus geometry
`define MST_DATA_W        32
`define MST_BE_W          4

// Buffer sizing, margin covers reads still in flight
`define MST_FIFO_DEPTH    16
`define MST_AFULL_MARGIN  3

`define MST_DWELL_CYCLES  4

`endif

// File: common/mst_bus_pkg.sv
/*
  Data-path types of the FIFO bus master
  Bus words, byte enables and the buffered word format
*/
`include "mst_fifo_settings.svh"

package mst_bus_pkg;

  // One word on the data pins
  typedef logic [`MST_DATA_W-1:0] bus_data_t;

  // Byte enables travelling with a word
  typedef logic [`MST_BE_W-1:0] bus_be_t;

  // Buffered unit, byte enables in the upper bits
  typedef logic [`MST_BE_W+`MST_DATA_W-1:0] bus_word_t;

endpackage

// File: common/mst_ctrl_pkg.sv
/*
  Control types of the FIFO bus master
  Bus state encoding and the idle dwell counter
*/
`include "mst_fifo_settings.svh"

package mst_ctrl_pkg;

  typedef enum logic [3:0] {
    RD_IDLE = 4'b0001,
    READ    = 4'b0010,
    WR_IDLE = 4'b0100,
    WRITE   = 4'b1000
  } mst_state_e;

  typedef logic [$clog2(`MST_DWELL_CYCLES+1)-1:0] dwell_cnt_t;

endpackage

// File: mst_fifo/mst_fifo_fsm.sv
/*
  Bus state machine of the FIFO master
  Alternates read and write phases and drives all strobes and enables
*/
`timescale 1ns/1ps

module mst_fifo_fsm (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     rxf_n,
  input  logic                     txe_n,
  input  logic                     rx_afull,
  input  logic                     stage_valid,
  input  logic                     tx_empty,
  input  logic                     dwell_done,
  output mst_ctrl_pkg::mst_state_e state,
  output logic                     rd_n,
  output logic                     oe_n,
  output logic                     wr_n,
  output logic                     dt_oe_n,
  output logic                     be_oe_n
);
  import mst_ctrl_pkg::*;

  logic rd_stop;
  logic wr_ready;
  logic wr_last;

  // Chip has nothing to offer or our receive side is nearly full
  assign rd_stop  = rxf_n | rx_afull;

  assign wr_ready = ~txe_n & (stage_valid | ~tx_empty);

  // Staged word goes out at this edge and nothing waits behind it
  assign wr_last  = tx_empty & (~stage_valid | ~wr_n);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= RD_IDLE;
      rd_n    <= 1'b1;
      oe_n    <= 1'b1;
      wr_n    <= 1'b1;
      dt_oe_n <= 1'b1;
      be_oe_n <= 1'b1;
    end
    else
    begin
      case (state)
        RD_IDLE:
        begin
          if (!rd_stop)
          begin
            // Chip takes the bus first, strobe follows
            state <= READ;
            oe_n  <= 1'b0;
          end
          else if (dwell_done)
          begin
            state <= WR_IDLE;
          end
        end

        READ:
        begin
          if (rd_stop)
          begin
            state <= WR_IDLE;
            oe_n  <= 1'b1;
            rd_n  <= 1'b1;
          end
          else
          begin
            rd_n <= 1'b0;
          end
        end

        WR_IDLE:
        begin
          if (wr_ready)
          begin
            // Drive the pins a cycle before the first strobe
            state   <= WRITE;
            dt_oe_n <= 1'b0;
            be_oe_n <= 1'b0;
          end
          else if (dwell_done)
          begin
            state <= RD_IDLE;
          end
        end

        WRITE:
        begin
          // Chip full or nothing left, release the bus
          if (txe_n || wr_last)
          begin
            state   <= RD_IDLE;
            wr_n    <= 1'b1;
            dt_oe_n <= 1'b1;
            be_oe_n <= 1'b1;
          end
          else
          begin
            wr_n <= 1'b0;
          end
        end

        default:
        begin
          state   <= RD_IDLE;
          rd_n    <= 1'b1;
          oe_n    <= 1'b1;
          wr_n    <= 1'b1;
          dt_oe_n <= 1'b1;
          be_oe_n <= 1'b1;
        end
      endcase
    end
  end

endmodule

// File: mst_fifo/mst_dwell_timer.sv
/*
  Idle dwell timer
  Counts cycles in an idle state and flags when the bus may turn around
*/
`timescale 1ns/1ps
`include "mst_fifo_settings.svh"

module mst_dwell_timer (
  input  logic                     clk,
  input  logic                     rst_n,
  input  mst_ctrl_pkg::mst_state_e state,
  output logic                     dwell_done
);
  import mst_ctrl_pkg::*;

  localparam dwell_cnt_t DWELL_LAST = dwell_cnt_t'(`MST_DWELL_CYCLES);

  mst_state_e state_q;
  dwell_cnt_t cnt;
  logic       in_idle;
  logic       settled;

  assign in_idle = (state == RD_IDLE) | (state == WR_IDLE);
  // Low for one cycle after every state change
  assign settled = (state == state_q);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= RD_IDLE;
      cnt     <= '0;
    end
    else
    begin
      state_q <= state;
      if (!settled)
        cnt <= '0;
      else if (in_idle && (cnt != DWELL_LAST))
        cnt <= cnt + dwell_cnt_t'(1);
    end
  end

  assign dwell_done = in_idle & settled & (cnt == DWELL_LAST);

endmodule

// File: mst_fifo/mst_rx_path.sv
/*
  Receive path of the FIFO master
  Captures each read word from the bus and pushes it into the receive buffer
*/
`timescale 1ns/1ps

module mst_rx_path (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   rd_n,
  input  logic                   oe_n,
  input  logic                   rxf_n,
  input  mst_bus_pkg::bus_data_t idata,
  input  mst_bus_pkg::bus_be_t   ibe,
  output logic                   rx_push,
  output mst_bus_pkg::bus_word_t rx_push_word
);
  import mst_bus_pkg::*;

  logic rd_xfer;

  // A word moves when both strobes and the chip flag are low
  assign rd_xfer = ~rd_n & ~oe_n & ~rxf_n;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rx_push <= 1'b0;
    else
      rx_push <= rd_xfer;
  end

  // Capture register, byte enables on top
  always_ff @(posedge clk)
  begin
    if (rd_xfer)
      rx_push_word <= {ibe, idata};
  end

endmodule

// File: mst_fifo/mst_tx_path.sv
/*
  Transmit path of the FIFO master
  Stages the next word onto odata/obe and keeps a word the chip refused
*/
`timescale 1ns/1ps

module mst_tx_path (
  input  logic                     clk,
  input  logic                     rst_n,
  input  mst_ctrl_pkg::mst_state_e state,
  input  logic                     wr_n,
  input  logic                     txe_n,
  input  mst_bus_pkg::bus_word_t   tx_head,
  input  logic                     tx_empty,
  output logic                     tx_pop,
  output logic                     stage_valid,
  output mst_bus_pkg::bus_data_t   odata,
  output mst_bus_pkg::bus_be_t     obe
);
  import mst_bus_pkg::*;
  import mst_ctrl_pkg::*;

  bus_word_t stage_word;
  logic      wr_accept;
  logic      stage_load;

  // Chip takes the staged word at this edge
  assign wr_accept  = (state == WRITE) & ~wr_n & ~txe_n & stage_valid;

  // Refill when empty or when the current word just left
  assign stage_load = ~tx_empty & (~stage_valid | wr_accept);
  assign tx_pop     = stage_load;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      stage_valid <= 1'b0;
    else if (stage_load)
      stage_valid <= 1'b1;
    else if (wr_accept)
      stage_valid <= 1'b0;
  end

  // Refused word stays put and leads the next burst.
  // Pins idle high whenever nothing is staged.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      stage_word <= '1;
    else if (stage_load)
      stage_word <= tx_head;
    else if (wr_accept)
      stage_word <= '1;
  end

  assign {obe, odata} = stage_word;

endmodule

// File: hdl/sync_fifo.sv
/*
  Synchronous show-ahead word buffer
  rdata holds the head word while empty is low, pop removes it
*/
`timescale 1ns/1ps
`include "mst_fifo_settings.svh"

module sync_fifo #(
  parameter int WIDTH = `MST_DATA_W + `MST_BE_W,
  parameter int DEPTH = `MST_FIFO_DEPTH
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             push,
  input  logic             pop,
  input  logic [WIDTH-1:0] wdata,
  output logic [WIDTH-1:0] rdata,
  output logic             full,
  output logic             almost_full,
  output logic             empty
);
  localparam int PTR_W       = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W       = $clog2(DEPTH + 1);
  localparam int AFULL_LEVEL = (DEPTH > `MST_AFULL_MARGIN) ? DEPTH - `MST_AFULL_MARGIN : 1;

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Wrap explicitly so any depth works
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1))
      return '0;
    return ptr + PTR_W'(1);
  endfunction

  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= wdata;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= ptr_next(wr_ptr);
      if (do_pop)
        rd_ptr <= ptr_next(rd_ptr);
      if (do_push && !do_pop)
        count <= count + CNT_W'(1);
      else if (do_pop && !do_push)
        count <= count - CNT_W'(1);
    end
  end

  assign rdata       = mem[rd_ptr];
  assign full        = (count == CNT_W'(DEPTH));
  assign almost_full = (count >= CNT_W'(AFULL_LEVEL));
  assign empty       = (count == '0);

endmodule

// File: hdl/mst_fifo_top.sv
/*
  Top level of the 245-style FIFO bus master
  Bus pins on one side, receive and transmit buffers on the user side
*/
`timescale 1ns/1ps
`include "mst_fifo_settings.svh"

module mst_fifo_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   txe_n,
  input  logic                   rxf_n,
  input  mst_bus_pkg::bus_data_t idata,
  input  mst_bus_pkg::bus_be_t   ibe,
  output mst_bus_pkg::bus_data_t odata,
  output mst_bus_pkg::bus_be_t   obe,
  output logic                   dt_oe_n,
  output logic                   be_oe_n,
  output logic                   wr_n,
  output logic                   rd_n,
  output logic                   oe_n,
  input  logic                   rx_pop,
  output mst_bus_pkg::bus_word_t rx_word,
  output logic                   rx_empty,
  input  logic                   tx_push,
  input  mst_bus_pkg::bus_word_t tx_word,
  output logic                   tx_full
);
  import mst_bus_pkg::*;
  import mst_ctrl_pkg::*;

  mst_state_e state;
  logic       dwell_done;
  logic       rx_push;
  bus_word_t  rx_push_word;
  logic       rx_afull;
  logic       stage_valid;
  logic       tx_pop;
  bus_word_t  tx_head;
  logic       tx_empty;

  mst_fifo_fsm u_fsm (
    .clk         (clk),
    .rst_n       (rst_n),
    .rxf_n       (rxf_n),
    .txe_n       (txe_n),
    .rx_afull    (rx_afull),
    .stage_valid (stage_valid),
    .tx_empty    (tx_empty),
    .dwell_done  (dwell_done),
    .state       (state),
    .rd_n        (rd_n),
    .oe_n        (oe_n),
    .wr_n        (wr_n),
    .dt_oe_n     (dt_oe_n),
    .be_oe_n     (be_oe_n)
  );

  mst_dwell_timer u_dwell (
    .clk        (clk),
    .rst_n      (rst_n),
    .state      (state),
    .dwell_done (dwell_done)
  );

  mst_rx_path u_rx_path (
    .clk          (clk),
    .rst_n        (rst_n),
    .rd_n         (rd_n),
    .oe_n         (oe_n),
    .rxf_n        (rxf_n),
    .idata        (idata),
    .ibe          (ibe),
    .rx_push      (rx_push),
    .rx_push_word (rx_push_word)
  );

  mst_tx_path u_tx_path (
    .clk         (clk),
    .rst_n       (rst_n),
    .state       (state),
    .wr_n        (wr_n),
    .txe_n       (txe_n),
    .tx_head     (tx_head),
    .tx_empty    (tx_empty),
    .tx_pop      (tx_pop),
    .stage_valid (stage_valid),
    .odata       (odata),
    .obe         (obe)
  );

  // Almost-full of the receive side throttles bus reads
  sync_fifo #(
    .WIDTH ($bits(bus_word_t)),
    .DEPTH (`MST_FIFO_DEPTH)
  ) rx_buf (
    .clk         (clk),
    .rst_n       (rst_n),
    .push        (rx_push),
    .pop         (rx_pop),
    .wdata       (rx_push_word),
    .rdata       (rx_word),
    .full        (),
    .almost_full (rx_afull),
    .empty       (rx_empty)
  );

  sync_fifo #(
    .WIDTH ($bits(bus_word_t)),
    .DEPTH (`MST_FIFO_DEPTH)
  ) tx_buf (
    .clk         (clk),
    .rst_n       (rst_n),
    .push        (tx_push),
    .pop         (tx_pop),
    .wdata       (tx_word),
    .rdata       (tx_head),
    .full        (tx_full),
    .almost_full (),
    .empty       (tx_empty)
  );

endmodule

// File: sim/tb_clk_gen.sv
/*
  Testbench clock and reset source
  4 ns clock, reset held low for the first 4 cycles
*/
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);
  localparam int HALF_PERIOD = 2;

  initial
  begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Released on a falling edge, away from the sampling edge
  initial
  begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// File: sim/mst_fifo_tb.sv
/*
  Directed testbench for the FIFO bus master
  A behavioral chip model serves reads and logs writes, one task per behavior
*/
`timescale 1ns/1ps
`include "mst_fifo_settings.svh"

module mst_fifo_tb;
  import mst_bus_pkg::*;

  localparam int AFULL_LEVEL = `MST_FIFO_DEPTH - `MST_AFULL_MARGIN;
  // Words moved by all tests together
  localparam int TOTAL_WORDS = 10 + 8 + 12 + 24 + 6 + 6;
  localparam int CYCLE_LIMIT = 20 * TOTAL_WORDS + 200;

  logic      clk;
  logic      rst_n;
  logic      txe_n   = 1'b0;
  logic      rxf_n   = 1'b1;
  bus_data_t idata   = '0;
  bus_be_t   ibe     = '0;
  logic      rx_pop  = 1'b0;
  logic      tx_push = 1'b0;
  bus_word_t tx_word = '0;
  bus_data_t odata;
  bus_be_t   obe;
  logic      dt_oe_n;
  logic      be_oe_n;
  logic      wr_n;
  logic      rd_n;
  logic      oe_n;
  bus_word_t rx_word;
  logic      rx_empty;
  logic      tx_full;

  // Chip model and scoreboard
  bus_word_t rd_q[$];
  bus_word_t wr_log[$];
  bus_word_t rx_exp[$];
  bus_word_t wr_exp[$];
  logic      rxf_gaps = 1'b0;
  logic      txe_gaps = 1'b0;
  int        rd_count = 0;
  int        rx_level = 0;
  int        cycles   = 0;

  tb_clk_gen u_clk (
    .clk   (clk),
    .rst_n (rst_n)
  );

  mst_fifo_top uut (
    .clk      (clk),
    .rst_n    (rst_n),
    .txe_n    (txe_n),
    .rxf_n    (rxf_n),
    .idata    (idata),
    .ibe      (ibe),
    .odata    (odata),
    .obe      (obe),
    .dt_oe_n  (dt_oe_n),
    .be_oe_n  (be_oe_n),
    .wr_n     (wr_n),
    .rd_n     (rd_n),
    .oe_n     (oe_n),
    .rx_pop   (rx_pop),
    .rx_word  (rx_word),
    .rx_empty (rx_empty),
    .tx_push  (tx_push),
    .tx_word  (tx_word),
    .tx_full  (tx_full)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(input string name, input bus_word_t got, input bus_word_t exp);
    if (got !== exp)
      abort_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_be(input string name, input bus_be_t got, input bus_be_t exp);
    if (got !== exp)
      abort_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
  endtask

  function automatic bus_word_t rand_word();
    bus_data_t data;
    bus_be_t   be;
    data = $urandom();
    be   = bus_be_t'($urandom_range(15));
    return {be, data};
  endfunction

  // Chip pins change on the falling edge only
  always @(negedge clk)
  begin
    rxf_n = (rd_q.size() == 0);
    if (rxf_gaps && ($urandom_range(3) == 0))
      rxf_n = 1'b1;
    if (rd_q.size() != 0)
      {ibe, idata} = rd_q[0];
    txe_n = txe_gaps && ($urandom_range(2) == 0);
  end

  // Bus transfers happen at the rising edge
  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT)
      abort_run("timeout: the tests did not finish within the cycle limit");
    else if (!rst_n)
      // Buffer is emptied by reset
      rx_level = 0;
    else if (!oe_n && (!dt_oe_n || !be_oe_n))
      abort_run("bus conflict: oe_n low while dt_oe_n or be_oe_n was low");
    else if (!rd_n && oe_n)
      abort_run("read strobe while the chip was not driving the bus");
    else
    begin
      if (!rd_n && !oe_n && !rxf_n)
      begin
        void'(rd_q.pop_front());
        rd_count = rd_count + 1;
        rx_level = rx_level + 1;
      end
      if (rx_pop && !rx_empty)
        rx_level = rx_level - 1;
      if (!wr_n && !txe_n)
        wr_log.push_back({obe, odata});
      if (rx_level > `MST_FIFO_DEPTH)
        abort_run("receive buffer overrun: more words read than it can hold");
    end
  end

  task automatic set_gaps(input logic rxf_on, input logic txe_on);
    @(posedge clk);
    rxf_gaps = rxf_on;
    txe_gaps = txe_on;
  endtask

  task automatic offer_reads(input int n);
    bus_word_t w;
    @(posedge clk);
    repeat (n)
    begin
      w = rand_word();
      rd_q.push_back(w);
      rx_exp.push_back(w);
    end
  endtask

  task automatic drain_rx(input int n);
    int        got;
    bus_word_t exp;
    got = 0;
    while (got < n)
    begin
      @(negedge clk);
      rx_pop = 1'b0;
      if (!rx_empty && (rx_exp.size() == 0))
        abort_run("receive buffer returned a word the chip never offered");
      else if (!rx_empty)
      begin
        exp = rx_exp.pop_front();
        check_be("rx_word be", rx_word[$bits(bus_word_t)-1 -: `MST_BE_W],
                 exp[$bits(bus_word_t)-1 -: `MST_BE_W]);
        check_word("rx_word", rx_word, exp);
        rx_pop = 1'b1;
        got    = got + 1;
      end
    end
    @(negedge clk);
    rx_pop = 1'b0;
  endtask

  task automatic push_tx(input int n);
    bus_word_t w;
    repeat (n)
    begin
      @(negedge clk);
      tx_push = 1'b0;
      while (tx_full)
        @(negedge clk);
      w       = rand_word();
      tx_word = w;
      tx_push = 1'b1;
      wr_exp.push_back(w);
    end
    @(negedge clk);
    tx_push = 1'b0;
  endtask

  task automatic wait_writes(input int n);
    @(negedge clk);
    while (wr_log.size() < n)
      @(negedge clk);
    repeat (n)
      check_word("write log", wr_log.pop_front(), wr_exp.pop_front());
  endtask

  task automatic reset_idle();
    @(negedge clk);
    check_level("wr_n", wr_n, 1'b1);
    check_level("rd_n", rd_n, 1'b1);
    check_level("oe_n", oe_n, 1'b1);
    check_level("dt_oe_n", dt_oe_n, 1'b1);
    check_level("be_oe_n", be_oe_n, 1'b1);
    check_be("obe", obe, '1);
    @(posedge rst_n);
    @(negedge clk);
    check_level("wr_n", wr_n, 1'b1);
    check_level("rd_n", rd_n, 1'b1);
    check_level("oe_n", oe_n, 1'b1);
    check_level("dt_oe_n", dt_oe_n, 1'b1);
    check_level("be_oe_n", be_oe_n, 1'b1);
    check_be("obe", obe, '1);
  endtask

  task automatic read_burst();
    offer_reads(10);
    drain_rx(10);
  endtask

  task automatic write_burst();
    push_tx(8);
    wait_writes(8);
  endtask

  // Refused words must come back first in the next burst
  task automatic write_backpressure();
    set_gaps(1'b0, 1'b1);
    push_tx(12);
    wait_writes(12);
    set_gaps(1'b0, 1'b0);
  endtask

  task automatic read_throttle();
    int base;
    @(negedge clk);
    base = rd_count;
    set_gaps(1'b1, 1'b0);
    offer_reads(24);
    @(negedge clk);
    while (rd_count - base < AFULL_LEVEL)
      @(negedge clk);
    // Hold off the user until the read phase has stopped
    while (!oe_n)
      @(negedge clk);
    drain_rx(24);
    set_gaps(1'b0, 1'b0);
  endtask

  task automatic bus_direction();
    offer_reads(6);
    push_tx(6);
    drain_rx(6);
    wait_writes(6);
  endtask

  initial
  begin
    void'($urandom(32'h5c8213ce));
    reset_idle();
    read_burst();
    write_burst();
    write_backpressure();
    read_throttle();
    bus_direction();
    @(negedge clk);
    check_level("rx_empty", rx_empty, 1'b1);
    if (wr_log.size() != 0)
      abort_run("write log holds words that were never pushed");
    else
    begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

// File: sources.f
+incdir+common
common/mst_bus_pkg.sv
common/mst_ctrl_pkg.sv
mst_fifo/mst_fifo_fsm.sv
mst_fifo/mst_dwell_timer.sv
mst_fifo/mst_rx_path.sv
mst_fifo/mst_tx_path.sv
hdl/sync_fifo.sv
hdl/mst_fifo_top.sv
sim/tb_clk_gen.sv
sim/mst_fifo_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the FIFO bus master testbench with Verilator and runs it.
# The exit status of the model decides pass or fail.
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  -f sources.f \
  --top-module mst_fifo_tb \
  -Mdir obj_dir \
  -o sim_mst_fifo

./obj_dir/sim_mst_fifo
